//--- list.f
verilog/xnor_conv_pkg.sv
verilog/conv_sequencer.sv
verilog/xnor_window.sv
verilog/majority_tree.sv
verilog/row_packer.sv
verilog/xnor_conv_top.sv
verif/xnor_conv_asserts.sv
verif/tb_xnor_conv.sv

//--- run_sim.sh
#!/bin/sh
# build and run the xnor conv testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_xnor_conv -f list.f -o sim_xnor_conv

status=0
./obj_dir/sim_xnor_conv > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- verif/tb_xnor_conv.sv
// testbench for the xnor conv engine, runs each test block of the data file through the dut
`timescale 1ns/1ps

module tb_xnor_conv;
	import xnor_conv_pkg::*;

	// ========================================================================
	// data file layout, one block of words per test
	// ========================================================================

	localparam int num_tests = 6;
	localparam int blk_words = 64;
	localparam int in_off    = 0;
	localparam int in_words  = 32;
	localparam int wgt_off   = 32;
	localparam int cnt_off   = 33;
	localparam int exp_off   = 34;
	localparam int clk_half  = 2;

	logic      clk;
	logic      reset_b;
	logic      dut_run;
	logic      dut_busy;
	addr_t     dut_sram_read_address;
	row_word_t sram_dut_read_data = '0;
	addr_t     dut_wmem_read_address;
	row_word_t wmem_dut_read_data = '0;
	addr_t     dut_sram_write_address;
	row_word_t dut_sram_write_data;
	logic      dut_sram_write_enable;

	// data file image and the three memories
	row_word_t tdata   [0:num_tests*blk_words-1];
	row_word_t sram    [0:4095];
	row_word_t wmem    [0:15];
	row_word_t out_mem [0:4095];

	int    errors = 0;
	int    checks = 0;
	int    exp_count = 0;
	// writes seen over the whole sim, and where this run started
	int    wr_count = 0;
	int    run_base = 0;
	int    wr_idx;
	string cur_name = "reset";
	int    wd_cycles = 0;
	logic  wd_armed = 1'b0;

	xnor_conv_top u_dut (
		.clk                    (clk),
		.reset_b                (reset_b),
		.dut_run                (dut_run),
		.dut_busy               (dut_busy),
		.dut_sram_read_address  (dut_sram_read_address),
		.sram_dut_read_data     (sram_dut_read_data),
		.dut_wmem_read_address  (dut_wmem_read_address),
		.wmem_dut_read_data     (wmem_dut_read_data),
		.dut_sram_write_address (dut_sram_write_address),
		.dut_sram_write_data    (dut_sram_write_data),
		.dut_sram_write_enable  (dut_sram_write_enable)
	);

	bind xnor_conv_top xnor_conv_asserts u_asserts (
		.clk                    (clk),
		.reset_b                (reset_b),
		.dut_busy               (dut_busy),
		.dut_sram_write_enable  (dut_sram_write_enable),
		.dut_sram_write_address (dut_sram_write_address)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	// ========================================================================
	// memory models
	// ========================================================================

	// one cycle read latency on both read ports
	always @(posedge clk) begin
		sram_dut_read_data <= sram[dut_sram_read_address];
		wmem_dut_read_data <= wmem[dut_wmem_read_address[3:0]];
	end

	// output sram, address checked as each write lands
	always @(posedge clk) begin
		if (reset_b && dut_sram_write_enable) begin
			wr_idx = wr_count - run_base;
			if (wr_idx < exp_count)
				check_addr($sformatf("%s addr %0d", cur_name, wr_idx), addr_t'(wr_idx),
					dut_sram_write_address);
			else
				report_failure($sformatf("%s wrote more than %0d words", cur_name, exp_count));
			out_mem[dut_sram_write_address] = dut_sram_write_data;
			wr_count++;
		end
	end

	// ========================================================================
	// helpers and compare tasks
	// ========================================================================

	function automatic row_word_t fill_word(input int a);
		return row_word_t'(a) ^ 16'hA5C3;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			0:       return "ones_16x16";
			1:       return "random_5x6";
			2:       return "two_images";
			3:       return "narrow_5x3";
			4:       return "end_only";
			default: return "rerun_5x6";
		endcase
	endfunction

	// pixels of all images, walked by their headers
	function automatic int watchdog_cycles();
		int total;
		int pos;
		int blk;
		total = 0;
		for (int t = 0; t < num_tests; t++) begin
			blk = t * blk_words + in_off;
			pos = 0;
			// slack for headers and drain
			total += 16;
			while (pos < in_words - 1 && tdata[blk + pos] != end_marker) begin
				total += int'(tdata[blk + pos]) * int'(tdata[blk + pos + 1]);
				pos += 2 + int'(tdata[blk + pos]);
			end
		end
		return total * 40;
	endfunction

	task automatic report_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic check_word(input string name, input row_word_t exp, input row_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("ERR %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic load_memories(input int blk);
		for (int a = 0; a < 4096; a++)
			sram[a] = (a < in_words) ? tdata[blk + in_off + a] : fill_word(a);
		for (int a = 0; a < 16; a++)
			wmem[a] = fill_word(a);
		// dimension word, never read by the engine
		wmem[0] = row_word_t'(kernel_dim);
		wmem[int'(weight_data_addr)] = tdata[blk + wgt_off];
	endtask

	// ========================================================================
	// one run per test block
	// ========================================================================

	task automatic run_test(input int t);
		int blk;
		int rise_wait;
		int n;
		blk = t * blk_words;
		load_memories(blk);
		cur_name  = test_name(t);
		exp_count = int'(tdata[blk + cnt_off]);
		run_base  = wr_count;
		@(posedge clk);
		dut_run <= 1'b1;
		// run held until busy shows up
		rise_wait = 0;
		do begin
			@(posedge clk);
			rise_wait++;
		end while (!dut_busy && rise_wait < 8);
		dut_run <= 1'b0;
		check_count({cur_name, " busy rise"}, 2, rise_wait);
		while (dut_busy)
			@(posedge clk);
		// every write lands before busy drops
		n = wr_count - run_base;
		check_count({cur_name, " writes"}, exp_count, n);
		for (int i = 0; i < exp_count && i < n; i++)
			check_word($sformatf("%s word %0d", cur_name, i), tdata[blk + exp_off + i],
				out_mem[i]);
		repeat (3) @(posedge clk);
	endtask

	initial begin
		dut_run = 1'b0;
		reset_b = 1'b0;
		for (int a = 0; a < num_tests * blk_words; a++)
			tdata[a] = fill_word(a);
		$readmemh("verif/xnor_conv_testdata.hex", tdata);
		wd_cycles = watchdog_cycles();
		wd_armed  = 1'b1;
		repeat (16) @(posedge clk);
		reset_b <= 1'b1;
		repeat (2) @(posedge clk);
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog, limit scales with the pixel count
	initial begin
		wait (wd_armed);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the engine did not finish", wd_cycles);
		$display("checks %0d errors %0d", checks, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verif/xnor_conv_asserts.sv
// concurrent checks on the write port and busy flag, bound into the conv engine top
`timescale 1ns/1ps

module xnor_conv_asserts (
	input logic                 clk,
	input logic                 reset_b,
	input logic                 dut_busy,
	input logic                 dut_sram_write_enable,
	input xnor_conv_pkg::addr_t dut_sram_write_address
);
	import xnor_conv_pkg::*;

	// last write address of this run
	addr_t prev_addr;
	logic  seen_write;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			prev_addr  <= '0;
			seen_write <= 1'b0;
		end else if (!dut_busy) begin
			seen_write <= 1'b0;
		end else if (dut_sram_write_enable) begin
			prev_addr  <= dut_sram_write_address;
			seen_write <= 1'b1;
		end
	end

	write_needs_busy: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |-> dut_busy)
		else $error("write enable high while the engine is idle");

	write_one_cycle: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable)
		else $error("write enable held for more than one cycle");

	// addresses step by one inside a run
	write_addr_step: assert property (@(posedge clk) disable iff (!reset_b)
		(dut_sram_write_enable && seen_write) |->
			(dut_sram_write_address == addr_t'(prev_addr + 1'b1)))
		else $error("write address skipped or repeated inside a run");

endmodule

//--- verif/xnor_conv_testdata.hex
// one 64-word block per test: +00 input sram words, +20 weight word,
// +21 expected write count, +22 expected output words in address order
// ones_16x16, all-ones image and kernel
@000
0010 0010
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
00FF
@020
01FF 000E
3FFF 3FFF 3FFF 3FFF 3FFF 3FFF 3FFF
3FFF 3FFF 3FFF 3FFF 3FFF 3FFF 3FFF
// random_5x6, upper bits of the rows are junk
@040
0005 0006 5A2D 91DA 3377 E4C9 0EB4 00FF
@060
00D6 0003 0003 000D 000C
// two_images, random_5x6 then narrow_5x3 in one run
@080
0005 0006 5A2D 91DA 3377 E4C9 0EB4
0005 0003 FFFB 8A2E 7F3D C0F3 12AF 00FF
@0A0
00D6 0006 0003 000D 000C 0000 0001 0001
// narrow_5x3, only bit 0 of each word is an output column
@0C0
0005 0003 FFFB 8A2E 7F3D C0F3 12AF 00FF
@0E0
00D6 0003 0000 0001 0001
// end_only, end marker at address 0
@100
00FF
@120
01FF 0000
// rerun_5x6, random_5x6 again on a fresh run
@140
0005 0006 5A2D 91DA 3377 E4C9 0EB4 00FF
@160
00D6 0003 0003 000D 000C

//--- verilog/conv_sequencer.sv
// run/busy fsm of the conv engine, reads headers, kernel and rows and streams columns
`timescale 1ns/1ps

module conv_sequencer (
	input  logic                     clk,
	input  logic                     reset_b,
	input  logic                     dut_run,
	input  xnor_conv_pkg::row_word_t sram_dut_read_data,
	input  xnor_conv_pkg::row_word_t wmem_dut_read_data,
	output logic                     dut_busy,
	output xnor_conv_pkg::addr_t     dut_sram_read_address,
	output xnor_conv_pkg::addr_t     dut_wmem_read_address,
	output logic                     pix_valid,
	output logic [2:0]               pix_col,
	output xnor_conv_pkg::col_idx_t  col_idx,
	output logic                     row_last_col,
	output logic                     kernel_load,
	output xnor_conv_pkg::kernel_t   kernel,
	output xnor_conv_pkg::col_idx_t  out_cols
);
	import xnor_conv_pkg::*;

	seq_state_t state;

	// three-row buffer, row_0 is the top row of the window
	row_word_t row_0;
	row_word_t row_1;
	row_word_t row_2;

	// image size minus one, low nibble only
	logic [3:0] rows_m1;
	col_idx_t   cols_m1;

	// bottom buffered row, current column
	logic [3:0] row_cnt;
	col_idx_t   col_cnt;

	// cycles left before busy drops
	logic [2:0] drain_cnt;

	logic last_col;
	logic last_row;

	assign last_col = (col_cnt == cols_m1);
	assign last_row = (row_cnt == rows_m1);

	// kernel word is valid here, wmem address was set on run start
	assign kernel_load = (state == s_read_cols);
	assign kernel      = wmem_dut_read_data[8:0];

	// ========================================================================
	// fsm and read addresses
	// ========================================================================

	// read data always belongs to the address held in the previous state,
	// so the address runs one word ahead of the state that takes it
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state                 <= s_idle;
			dut_busy              <= 1'b0;
			dut_sram_read_address <= '0;
			dut_wmem_read_address <= '0;
			row_cnt               <= '0;
			col_cnt               <= '0;
			drain_cnt             <= '0;
			pix_valid             <= 1'b0;
		end else begin
			// one streamed column per stream cycle
			pix_valid <= (state == s_stream);
			case (state)
				s_idle: begin
					// run only looked at here
					if (dut_run) begin
						state                 <= s_read_rows;
						dut_busy              <= 1'b1;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						dut_wmem_read_address <= weight_data_addr;
					end
				end
				s_read_rows: begin
					// rows word on the bus
					if (sram_dut_read_data == end_marker) begin
						state     <= s_drain;
						drain_cnt <= 3'(pipe_depth);
					end else begin
						state                 <= s_read_cols;
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
					end
				end
				s_read_cols: begin
					state                 <= s_fill_r0;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
				end
				s_fill_r0: begin
					state                 <= s_fill_r1;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					// bottom row index once the buffer is full
					row_cnt               <= 4'(kernel_dim - 1);
				end
				s_fill_r1: begin
					state                 <= s_fill_r2;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
				end
				s_fill_r2: begin
					state   <= s_stream;
					col_cnt <= '0;
				end
				s_stream: begin
					col_cnt <= col_cnt + 1'b1;
					if (last_col) begin
						if (last_row) begin
							// address already sits on the next header
							state                 <= s_read_rows;
							dut_sram_read_address <= dut_sram_read_address + 1'b1;
						end else begin
							state <= s_next_row;
						end
					end
				end
				s_next_row: begin
					// next row comes back in fill_r2
					state                 <= s_fill_r2;
					dut_sram_read_address <= dut_sram_read_address + 1'b1;
					row_cnt               <= row_cnt + 1'b1;
				end
				s_drain: begin
					// let the last row write finish before dropping busy
					if (drain_cnt == '0) begin
						state                 <= s_idle;
						dut_busy              <= 1'b0;
						dut_sram_read_address <= '0;
						dut_wmem_read_address <= '0;
					end else begin
						drain_cnt <= drain_cnt - 1'b1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// ========================================================================
	// row buffer and column stream
	// ========================================================================

	always_ff @(posedge clk) begin
		// column bits, bit k from buffered row k
		pix_col      <= {row_2[col_cnt], row_1[col_cnt], row_0[col_cnt]};
		col_idx      <= col_cnt;
		row_last_col <= last_col;
		case (state)
			s_read_rows: rows_m1 <= sram_dut_read_data[3:0] - 4'd1;
			s_read_cols: cols_m1 <= sram_dut_read_data[3:0] - 4'd1;
			s_fill_r0:   row_0   <= sram_dut_read_data;
			s_fill_r1:   row_1   <= sram_dut_read_data;
			s_fill_r2: begin
				row_2    <= sram_dut_read_data;
				// late update, previous image votes are through by now
				out_cols <= cols_m1 - col_idx_t'(kernel_dim - 2);
			end
			s_next_row: begin
				// move buffer up one row
				row_0 <= row_1;
				row_1 <= row_2;
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/majority_tree.sv
// two-stage full adder tree, nine mismatch flags in, one vote bit out two cycles later
`timescale 1ns/1ps

module majority_tree (
	input  logic                    clk,
	input  logic                    reset_b,
	input  logic                    win_valid,
	input  xnor_conv_pkg::window_t  win_flags,
	input  xnor_conv_pkg::col_idx_t win_col,
	input  logic                    win_row_end,
	output logic                    vote_valid,
	output logic                    vote,
	output xnor_conv_pkg::col_idx_t vote_col,
	output logic                    vote_row_end
);
	import xnor_conv_pkg::*;

	// {carry, sum}
	function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
		full_add = {(a & b) | (c & (a ^ b)), a ^ b ^ c};
	endfunction

	// stage 1, one adder per kernel row
	logic [2:0] s1_sum_d;
	logic [2:0] s1_carry_d;
	logic [2:0] s1_sum;
	logic [2:0] s1_carry;
	logic       s1_valid;
	col_idx_t   s1_col;
	logic       s1_row_end;

	// stage 2 weights
	logic       ones;
	logic       twos_a;
	logic       twos_b;
	logic       fours;
	logic [3:0] mis_count;

	always_comb begin
		for (int k = 0; k < kernel_dim; k++)
			{s1_carry_d[k], s1_sum_d[k]} = full_add(win_flags[3*k], win_flags[3*k+1],
				win_flags[3*k+2]);
	end

	// sums give ones and one twos, carries give the other twos and fours
	assign {twos_a, ones}  = full_add(s1_sum[0], s1_sum[1], s1_sum[2]);
	assign {fours, twos_b} = full_add(s1_carry[0], s1_carry[1], s1_carry[2]);
	assign mis_count = {1'b0, fours, 2'b00} + {2'b00, twos_a, 1'b0} +
		{2'b00, twos_b, 1'b0} + {3'b000, ones};

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid   <= 1'b0;
			vote_valid <= 1'b0;
		end else begin
			s1_valid   <= win_valid;
			vote_valid <= s1_valid;
		end
	end

	// partial sums, tags ride along
	always_ff @(posedge clk) begin
		s1_sum       <= s1_sum_d;
		s1_carry     <= s1_carry_d;
		s1_col       <= win_col;
		s1_row_end   <= win_row_end;
		vote         <= (mis_count <= 4'(vote_threshold));
		vote_col     <= s1_col;
		vote_row_end <= s1_row_end;
	end

endmodule

//--- verilog/row_packer.sv
// packs vote bits into one output row word and writes it to the output sram on row end
`timescale 1ns/1ps

module row_packer (
	input  logic                     clk,
	input  logic                     reset_b,
	input  logic                     dut_busy,
	input  logic                     vote_valid,
	input  logic                     vote,
	input  xnor_conv_pkg::col_idx_t  vote_col,
	input  logic                     vote_row_end,
	input  xnor_conv_pkg::col_idx_t  out_cols,
	output xnor_conv_pkg::addr_t     dut_sram_write_address,
	output xnor_conv_pkg::row_word_t dut_sram_write_data,
	output logic                     dut_sram_write_enable
);
	import xnor_conv_pkg::*;

	// bits of the row so far
	row_word_t acc;
	row_word_t acc_next;
	row_word_t vote_bit;
	logic      bit_en;
	logic      row_done;

	// columns at or past out_cols stay zero
	assign bit_en   = vote_valid && vote && (vote_col < out_cols);
	assign vote_bit = bit_en ? (row_word_t'(1) << vote_col) : '0;
	assign acc_next = acc | vote_bit;

	// last vote of the row is folded in on the same edge
	assign row_done = vote_valid && vote_row_end;

	// ========================================================================
	// accumulator and write port
	// ========================================================================

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc                    <= '0;
			dut_sram_write_enable  <= 1'b0;
			dut_sram_write_address <= '0;
		end else begin
			// single cycle write pulse
			dut_sram_write_enable <= row_done;
			if (row_done)
				acc <= '0;
			else
				acc <= acc_next;
			// count up across images, restart on every run
			if (!dut_busy)
				dut_sram_write_address <= '0;
			else if (dut_sram_write_enable)
				dut_sram_write_address <= dut_sram_write_address + 1'b1;
		end
	end

	// data word for the write pulse
	always_ff @(posedge clk) begin
		if (row_done)
			dut_sram_write_data <= acc_next;
	end

endmodule

//--- verilog/xnor_conv_pkg.sv
// shared widths, types, states and memory map of the binary conv engine, imported by rtl and tb
package xnor_conv_pkg;

	// ========================================================================
	// widths
	// ========================================================================

	// sram word address
	typedef logic [11:0] addr_t;
	// one image row or one output row, bit c is column c
	typedef logic [15:0] row_word_t;
	// column index inside a row word
	typedef logic [3:0] col_idx_t;
	// kernel bits, bit 3k+m is kernel row k, column m
	typedef logic [8:0] kernel_t;
	// mismatch flags, same bit order as the kernel
	typedef logic [8:0] window_t;

	// ========================================================================
	// sequencer states
	// ========================================================================

	typedef enum logic [3:0] {
		s_idle,
		s_read_rows,
		s_read_cols,
		s_fill_r0,
		s_fill_r1,
		s_fill_r2,
		s_stream,
		s_next_row,
		s_drain
	} seq_state_t;

	// ========================================================================
	// constants and memory map
	// ========================================================================

	// fixed 3x3 kernel
	localparam int kernel_dim = 3;
	// kernel data word, dimension word at 0 is never read
	localparam addr_t weight_data_addr = 12'd1;
	// rows word that ends the image list
	localparam row_word_t end_marker = 16'h00FF;
	// largest mismatch count that still votes 1
	localparam int vote_threshold = 4;
	// streamed column to vote bit at the packer
	localparam int pipe_depth = 5;

endpackage

//--- verilog/xnor_conv_top.sv
// top of the xnor 3x3 conv engine, wires sequencer, window, majority tree and row packer
`timescale 1ns/1ps

module xnor_conv_top (
	input  logic                     clk,
	input  logic                     reset_b,
	input  logic                     dut_run,
	output logic                     dut_busy,
	output xnor_conv_pkg::addr_t     dut_sram_read_address,
	input  xnor_conv_pkg::row_word_t sram_dut_read_data,
	output xnor_conv_pkg::addr_t     dut_wmem_read_address,
	input  xnor_conv_pkg::row_word_t wmem_dut_read_data,
	output xnor_conv_pkg::addr_t     dut_sram_write_address,
	output xnor_conv_pkg::row_word_t dut_sram_write_data,
	output logic                     dut_sram_write_enable
);
	import xnor_conv_pkg::*;

	// sequencer -> window
	logic       pix_valid;
	logic [2:0] pix_col;
	col_idx_t   col_idx;
	logic       row_last_col;
	logic       kernel_load;
	kernel_t    kernel;
	col_idx_t   out_cols;

	// window -> tree
	logic       win_valid;
	window_t    win_flags;
	col_idx_t   win_col;
	logic       win_row_end;

	// tree -> packer
	logic       vote_valid;
	logic       vote;
	col_idx_t   vote_col;
	logic       vote_row_end;

	// ========================================================================
	// control and memory reads
	// ========================================================================

	conv_sequencer u_seq (
		.clk                   (clk),
		.reset_b               (reset_b),
		.dut_run               (dut_run),
		.sram_dut_read_data    (sram_dut_read_data),
		.wmem_dut_read_data    (wmem_dut_read_data),
		.dut_busy              (dut_busy),
		.dut_sram_read_address (dut_sram_read_address),
		.dut_wmem_read_address (dut_wmem_read_address),
		.pix_valid             (pix_valid),
		.pix_col               (pix_col),
		.col_idx               (col_idx),
		.row_last_col          (row_last_col),
		.kernel_load           (kernel_load),
		.kernel                (kernel),
		.out_cols              (out_cols)
	);

	// ========================================================================
	// datapath
	// ========================================================================

	xnor_window u_win (
		.clk          (clk),
		.reset_b      (reset_b),
		.pix_valid    (pix_valid),
		.pix_col      (pix_col),
		.col_idx      (col_idx),
		.row_last_col (row_last_col),
		.kernel_load  (kernel_load),
		.kernel       (kernel),
		.win_valid    (win_valid),
		.win_flags    (win_flags),
		.win_col      (win_col),
		.win_row_end  (win_row_end)
	);

	majority_tree u_tree (
		.clk          (clk),
		.reset_b      (reset_b),
		.win_valid    (win_valid),
		.win_flags    (win_flags),
		.win_col      (win_col),
		.win_row_end  (win_row_end),
		.vote_valid   (vote_valid),
		.vote         (vote),
		.vote_col     (vote_col),
		.vote_row_end (vote_row_end)
	);

	row_packer u_pack (
		.clk                    (clk),
		.reset_b                (reset_b),
		.dut_busy               (dut_busy),
		.vote_valid             (vote_valid),
		.vote                   (vote),
		.vote_col               (vote_col),
		.vote_row_end           (vote_row_end),
		.out_cols               (out_cols),
		.dut_sram_write_address (dut_sram_write_address),
		.dut_sram_write_data    (dut_sram_write_data),
		.dut_sram_write_enable  (dut_sram_write_enable)
	);

endmodule

//--- verilog/xnor_window.sv
// kernel register and 3x3 pixel shift window, gives the nine mismatch flags per output pixel
`timescale 1ns/1ps

module xnor_window (
	input  logic                    clk,
	input  logic                    reset_b,
	input  logic                    pix_valid,
	input  logic [2:0]              pix_col,
	input  xnor_conv_pkg::col_idx_t col_idx,
	input  logic                    row_last_col,
	input  logic                    kernel_load,
	input  xnor_conv_pkg::kernel_t  kernel,
	output logic                    win_valid,
	output xnor_conv_pkg::window_t  win_flags,
	output xnor_conv_pkg::col_idx_t win_col,
	output logic                    win_row_end
);
	import xnor_conv_pkg::*;

	kernel_t    kernel_q;
	// pixels in kernel bit order, column 2 is the newest
	window_t    pix_win;
	window_t    pix_next;
	// columns shifted in this row, saturates at 2
	logic [1:0] fill_cnt;

	// shift left by one column, new column enters at m=2
	always_comb begin
		for (int k = 0; k < kernel_dim; k++) begin
			pix_next[3*k]     = pix_win[3*k+1];
			pix_next[3*k + 1] = pix_win[3*k+2];
			pix_next[3*k + 2] = pix_col[k];
		end
	end

	// mismatch where pixel and weight differ
	assign win_flags = pix_win ^ kernel_q;

	// ========================================================================
	// fill control
	// ========================================================================

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			fill_cnt  <= '0;
			win_valid <= 1'b0;
		end else begin
			// full window once this is the third column
			win_valid <= pix_valid && (fill_cnt == 2'(kernel_dim - 1));
			if (pix_valid) begin
				if (row_last_col)
					fill_cnt <= '0;
				else if (fill_cnt != 2'(kernel_dim - 1))
					fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	// ========================================================================
	// window and tags
	// ========================================================================

	always_ff @(posedge clk) begin
		if (kernel_load)
			kernel_q <= kernel;
		if (pix_valid)
			pix_win <= pix_next;
		// output column is the leftmost window column
		win_col     <= col_idx - col_idx_t'(kernel_dim - 1);
		win_row_end <= pix_valid && row_last_col;
	end

endmodule
